// ==== list.f ====
+incdir+sim
logic/rv_pkg.sv
logic/unified_mem.sv
logic/mem_arbiter.sv
logic/alu.sv
logic/fetch_unit.sv
logic/decode_unit.sv
logic/exec_unit.sv
logic/lsu.sv
logic/core_top.sv
sim/core_tb.sv

// ==== sim/ref_model.svh ====
logic [xlen-1:0] m_regs [32];         // architectural registers, x0 kept zero
logic [xlen-1:0] m_mem  [mem_words];  // word image of program and data
logic [xlen-1:0] m_pc;

// rv32i integer result for funct3, alt selects sub or sra
function automatic logic [xlen-1:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [xlen-1:0] a,
                                            input logic [xlen-1:0] b);
  case (f3)
    3'd0: alu_ref = alt ? a - b : a + b;
    3'd1: alu_ref = a << b[4:0];
    3'd2: alu_ref = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'd3: alu_ref = (a < b) ? 32'd1 : 32'd0;
    3'd4: alu_ref = a ^ b;
    3'd5: begin
      if (alt) alu_ref = $signed(a) >>> b[4:0];  // sign fill
      else alu_ref = a >> b[4:0];
    end
    3'd6: alu_ref = a | b;
    default: alu_ref = a & b;
  endcase
endfunction

// executes the instruction at m_pc and reports what should retire
function automatic void ref_model_step(output logic [xlen-1:0] e_pc, output logic e_wen,
                                       output logic [4:0] e_rd,
                                       output logic [xlen-1:0] e_data);
  logic [xlen-1:0] inst, a, b, imm_i, imm_s, imm_b, imm_j, addr, word, lane, mask, next;
  logic [2:0]      f3;
  logic            taken;
  inst  = m_mem[m_pc[aw+1:2]];
  f3    = inst[14:12];
  a     = m_regs[inst[19:15]];
  b     = m_regs[inst[24:20]];
  imm_i = {{20{inst[31]}}, inst[31:20]};
  imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
  addr  = a + ((inst[6:0] == 7'h23) ? imm_s : imm_i);  // effective byte address
  word  = m_mem[addr[aw+1:2]];
  lane  = word >> (8 * addr[1:0]);  // addressed byte at bit 0
  next  = m_pc + 32'd4;
  taken = 1'b0;
  e_pc  = m_pc;
  e_rd  = inst[11:7];
  e_wen = 1'b1;
  e_data = '0;
  case (inst[6:0])
    7'h13: e_data = alu_ref(f3, inst[30] && f3 == 3'd5, a, imm_i);  // only srai alternates
    7'h33: e_data = alu_ref(f3, inst[30], a, b);
    7'h37: e_data = {inst[31:12], 12'b0};
    7'h17: e_data = m_pc + {inst[31:12], 12'b0};
    7'h6f: begin
      e_data = m_pc + 32'd4;
      next   = m_pc + imm_j;
    end
    7'h67: begin
      e_data = m_pc + 32'd4;
      next   = (a + imm_i) & ~32'd1;
    end
    7'h63: begin
      e_wen = 1'b0;
      case (f3)
        3'd0: taken = a == b;
        3'd1: taken = a != b;
        3'd4: taken = $signed(a) < $signed(b);
        3'd5: taken = $signed(a) >= $signed(b);
        3'd6: taken = a < b;
        3'd7: taken = a >= b;
        default: taken = 1'b0;
      endcase
      if (taken) next = m_pc + imm_b;
    end
    7'h03: begin
      case (f3)
        3'd0: e_data = {{24{lane[7]}}, lane[7:0]};
        3'd1: e_data = {{16{lane[15]}}, lane[15:0]};
        3'd4: e_data = {24'b0, lane[7:0]};
        3'd5: e_data = {16'b0, lane[15:0]};
        default: e_data = word;
      endcase
    end
    7'h23: begin
      e_wen = 1'b0;
      mask  = (f3 == 3'd0) ? 32'h0000_00ff : (f3 == 3'd1) ? 32'h0000_ffff : 32'hffff_ffff;
      mask  = mask << (8 * addr[1:0]);
      m_mem[addr[aw+1:2]] = (word & ~mask) | ((b << (8 * addr[1:0])) & mask);  // merge lanes
    end
    default: e_wen = 1'b0;
  endcase
  if (e_wen && e_rd != 5'd0) m_regs[e_rd] = e_data;
  m_pc = next;
endfunction

// ==== sim/core_tb.sv ====
`timescale 1ns/1ps

module core_tb;
  import rv_pkg::*;

  localparam int mem_words   = 1024;
  localparam int aw          = $clog2(mem_words);
  localparam int max_retires = 200;
  localparam int wait_limit  = 64;  // cycles allowed per retire

  logic            clock, reset, run, load_we;
  logic [xlen-1:0] load_addr, load_data;
  logic            retire_valid, retire_wen;
  logic [xlen-1:0] retire_pc, retire_data;
  logic [4:0]      retire_rd;
  integer          seed = 32'he51e8640;

  `include "ref_model.svh"

  core_top #(.mem_words(mem_words)) u_core_top (
    .clock (clock), .reset (reset), .run (run), .load_we (load_we),
    .load_addr (load_addr), .load_data (load_data), .retire_valid (retire_valid),
    .retire_pc (retire_pc), .retire_wen (retire_wen), .retire_rd (retire_rd),
    .retire_data (retire_data)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;  // 8 ns period
  end

  task automatic stop_on_error(input string reason);
    $display("%s", reason);
    $display("Done: errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [xlen-1:0] expected,
                             input logic [xlen-1:0] actual);
    if (actual !== expected) begin
      stop_on_error($sformatf("** Error %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  function automatic int unsigned rnd(input int unsigned n);
    rnd = $unsigned($random(seed)) % n;
  endfunction

  // data region fill that mixes every address bit
  function automatic logic [xlen-1:0] fill_word(input int unsigned w);
    fill_word = (w * 32'h9e3779b1) ^ {16'(w), ~16'(w)};
  endfunction

  // instruction for program word idx
  // prefix words set the x31 base and seed x1..x30
  function automatic logic [xlen-1:0] gen_inst(input int idx);
    int unsigned kind, off;
    logic [2:0]  f3;
    logic [4:0]  rd, rs1, rs2;
    logic [11:0] imm;
    logic [6:0]  f7;
    logic [12:0] boff;
    logic [20:0] joff;
    kind = rnd(16);
    f3   = 3'(rnd(8));
    rd   = 5'(rnd(31));  // x31 stays the base
    rs1  = 5'(rnd(32));
    rs2  = 5'(rnd(32));
    imm  = 12'(rnd(4096));
    f7   = (rnd(2) == 0) ? 7'h20 : 7'h00;
    boff = 13'(4 * (1 + rnd(4)));  // forward only
    joff = 21'(4 * (1 + rnd(4)));
    off  = rnd(64);
    if (idx == 0) return {20'h1, 5'd31, 7'h37};  // lui x31, 1
    if (idx == 1) return {12'hc00, 5'd31, 3'b000, 5'd31, 7'h13};  // base 3072 is word 768
    if (idx < 32) return {imm, 5'd0, 3'b000, 5'(idx - 1), 7'h13};
    case (kind)
      0, 1, 2, 3: begin
        if (f3 == 3'd1) imm = {7'h00, imm[4:0]};
        else if (f3 == 3'd5) imm = {f7, imm[4:0]};  // srli or srai
        gen_inst = {imm, rs1, f3, rd, 7'h13};
      end
      4, 5: begin
        if (f3 != 3'd0 && f3 != 3'd5) f7 = 7'h00;
        gen_inst = {f7, rs2, rs1, f3, rd, 7'h33};
      end
      6: gen_inst = {20'(rnd(1 << 20)), rd, 7'h37};
      7: gen_inst = {20'(rnd(1 << 20)), rd, 7'h17};
      8, 9: begin
        f3 = 3'(rnd(5));
        if (f3 > 3'd2) f3 = f3 + 3'd1;  // lb lh lw lbu lhu
        imm = 12'(off & ~((1 << f3[1:0]) - 1));  // aligned offset
        gen_inst = {imm, 5'd31, f3, rd, 7'h03};
      end
      10, 11: begin
        f3  = 3'(rnd(3));
        imm = 12'(off & ~((1 << f3[1:0]) - 1));
        gen_inst = {imm[11:5], rs2, 5'd31, f3, imm[4:0], 7'h23};
      end
      12, 13: begin
        f3 = 3'(rnd(6));
        if (f3 > 3'd1) f3 = f3 + 3'd2;  // skip funct3 010 and 011
        gen_inst = {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11], 7'h63};
      end
      14: gen_inst = {joff[20], joff[10:1], joff[11], joff[19:12], rd, 7'h6f};
      default: begin
        imm = 12'(4 * (idx + 1 + rnd(4)));  // absolute target off x0
        gen_inst = {imm, 5'd0, 3'b000, rd, 7'h67};
      end
    endcase
  endfunction

  task automatic load_word(input int w, input logic [xlen-1:0] value);
    @(posedge clock);
    load_we   <= 1'b1;
    load_addr <= xlen'(w * 4);  // byte address
    load_data <= value;
    m_mem[w] = value;
  endtask

  // any retire while run is low fails
  task automatic expect_idle(input int cycles);
    int count;
    count = 0;
    while (count < cycles) begin
      @(negedge clock);
      if (retire_valid) stop_on_error("an instruction retired while run was low");
      count++;
    end
  endtask

  task automatic wait_retire();
    int cycles;
    cycles = 0;
    @(negedge clock);
    while (!retire_valid && cycles < wait_limit) begin
      @(negedge clock);
      cycles++;
    end
    if (!retire_valid) stop_on_error("no instruction retired within the timeout");
  endtask

  initial begin
    reset     = 1'b1;
    run       = 1'b0;
    load_we   = 1'b0;
    load_addr = '0;
    load_data = '0;
    for (int i = 0; i < 32; i++) m_regs[i] = '0;
    m_pc = '0;
    repeat (5) @(posedge clock);
    reset <= 1'b0;
    for (int w = 0; w < 256; w++) load_word(w, gen_inst(w));  // program
    for (int w = 512; w < mem_words; w++) load_word(w, fill_word(w));  // data region
    @(posedge clock);
    load_we <= 1'b0;
    expect_idle(40);
    @(posedge clock);
    run <= 1'b1;
  end

  // retire comparison against the model
  initial begin
    logic [xlen-1:0] e_pc, e_data;
    logic            e_wen;
    logic [4:0]      e_rd;
    int              n, waited;
    n      = 0;
    waited = 0;
    while (run !== 1'b1 && waited < 5000) begin
      @(negedge clock);
      waited++;
    end
    if (run !== 1'b1) stop_on_error("run was never raised after loading");
    while (n < max_retires && m_pc < 32'd1024) begin  // end of program words
      wait_retire();
      ref_model_step(e_pc, e_wen, e_rd, e_data);
      check_value($sformatf("retire %0d pc", n), e_pc, retire_pc);
      check_value($sformatf("retire %0d wen", n), xlen'(e_wen), xlen'(retire_wen));
      if (e_wen) begin
        check_value($sformatf("retire %0d rd", n), xlen'(e_rd), xlen'(retire_rd));
        check_value($sformatf("retire %0d data", n), e_data, retire_data);
      end
      n++;
    end
    $display("Done: no errors");
    $finish;
  end

endmodule

// ==== logic/core_top.sv ====
`timescale 1ns/1ps

module core_top #(
  parameter int mem_words = 1024
) (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    run,
  input  logic                    load_we,
  input  logic [rv_pkg::xlen-1:0] load_addr,
  input  logic [rv_pkg::xlen-1:0] load_data,
  output logic                    retire_valid,
  output logic [rv_pkg::xlen-1:0] retire_pc,
  output logic                    retire_wen,
  output logic [4:0]              retire_rd,
  output logic [rv_pkg::xlen-1:0] retire_data
);
  import rv_pkg::*;

  logic [$clog2(mem_words)-1:0] mem_addr;
  logic [xlen-1:0] mem_rdata, mem_wdata, rdata;
  logic [3:0]      mem_wmask, lsu_wmask, wmask;
  logic            mem_we, lsu_req, lsu_we, lsu_rvalid, lsu_wdone, lsu_done;
  logic [xlen-1:0] lsu_addr_out, lsu_wdata, load_data_ext;
  logic            fetch_req, fetch_rvalid, inst_valid, in_valid, out_valid;
  logic [xlen-1:0] fetch_addr, inst, inst_pc;
  opcode_t         op;
  logic [2:0]      func, load_ctrl;
  logic [xlen-1:0] src1, src2, imm, pc, upc, wb_data, ex_lsu_addr, store_data;
  logic            jump, reg_wen, need_lsu, mem_wen;

  unified_mem #(.mem_words(mem_words)) u_mem (
    .clock (clock), .addr (mem_addr), .wdata (mem_wdata), .wmask (mem_wmask),
    .we (mem_we), .rdata (mem_rdata)
  );

  mem_arbiter #(.mem_words(mem_words)) u_arb (
    .clock (clock), .reset (reset), .load_we (load_we), .load_addr (load_addr),
    .load_data (load_data), .lsu_req (lsu_req), .lsu_we (lsu_we), .lsu_addr (lsu_addr_out),
    .lsu_wdata (lsu_wdata), .lsu_wmask (lsu_wmask), .fetch_req (fetch_req),
    .fetch_addr (fetch_addr), .mem_rdata (mem_rdata), .lsu_rvalid (lsu_rvalid),
    .lsu_wdone (lsu_wdone), .fetch_rvalid (fetch_rvalid), .rdata (rdata),
    .mem_addr (mem_addr), .mem_wdata (mem_wdata), .mem_wmask (mem_wmask), .mem_we (mem_we)
  );

  fetch_unit u_fetch (
    .clock (clock), .reset (reset), .run (run), .fetch_rvalid (fetch_rvalid), .rdata (rdata),
    .retire (retire_valid), .jump (jump), .upc (upc), .fetch_req (fetch_req),
    .fetch_addr (fetch_addr), .inst_valid (inst_valid), .inst (inst), .inst_pc (inst_pc)
  );

  decode_unit u_dec (
    .clock (clock), .reset (reset), .inst_valid (inst_valid), .inst (inst),
    .inst_pc (inst_pc), .out_valid (out_valid), .need_lsu (need_lsu), .reg_wen (reg_wen),
    .wb_data (wb_data), .lsu_done (lsu_done), .load_data (load_data_ext),
    .in_valid (in_valid), .op (op), .func (func), .src1 (src1), .src2 (src2), .imm (imm),
    .pc (pc), .retire (retire_valid), .retire_pc (retire_pc), .retire_wen (retire_wen),
    .retire_rd (retire_rd), .retire_data (retire_data)
  );

  exec_unit u_exec (
    .clock (clock), .reset (reset), .in_valid (in_valid), .op (op), .func (func),
    .src1 (src1), .src2 (src2), .imm (imm), .pc (pc), .out_valid (out_valid), .jump (jump),
    .upc (upc), .reg_wen (reg_wen), .wb_data (wb_data), .need_lsu (need_lsu),
    .mem_wen (mem_wen), .wmask (wmask), .load_ctrl (load_ctrl), .lsu_addr (ex_lsu_addr),
    .store_data (store_data)
  );

  lsu u_lsu (
    .clock (clock), .reset (reset), .out_valid (out_valid), .need_lsu (need_lsu),
    .mem_wen (mem_wen), .wmask (wmask), .load_ctrl (load_ctrl), .lsu_addr (ex_lsu_addr),
    .store_data (store_data), .lsu_rvalid (lsu_rvalid), .lsu_wdone (lsu_wdone),
    .rdata (rdata), .lsu_req (lsu_req), .lsu_we (lsu_we), .lsu_addr_out (lsu_addr_out),
    .lsu_wdata (lsu_wdata), .lsu_wmask (lsu_wmask), .lsu_done (lsu_done),
    .load_data (load_data_ext)
  );

endmodule

// ==== logic/lsu.sv ====
`timescale 1ns/1ps

module lsu (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    out_valid,
  input  logic                    need_lsu,
  input  logic                    mem_wen,
  input  logic [3:0]              wmask,
  input  logic [2:0]              load_ctrl,
  input  logic [rv_pkg::xlen-1:0] lsu_addr,
  input  logic [rv_pkg::xlen-1:0] store_data,
  input  logic                    lsu_rvalid,
  input  logic                    lsu_wdone,
  input  logic [rv_pkg::xlen-1:0] rdata,
  output logic                    lsu_req,
  output logic                    lsu_we,
  output logic [rv_pkg::xlen-1:0] lsu_addr_out,
  output logic [rv_pkg::xlen-1:0] lsu_wdata,
  output logic [3:0]              lsu_wmask,
  output logic                    lsu_done,
  output logic [rv_pkg::xlen-1:0] load_data
);
  import rv_pkg::*;

  logic [2:0]      ld_ctrl;  // load width and sign kept for the answer
  logic [xlen-1:0] shifted;  // addressed byte moved to lane 0

  always_ff @(posedge clock) begin
    if (reset) begin
      lsu_req <= 1'b0;
      lsu_we  <= 1'b0;
    end else if (out_valid && need_lsu) begin
      lsu_req <= 1'b1;
      lsu_we  <= mem_wen;
    end else if (lsu_done) begin
      lsu_req <= 1'b0;  // answered, drop request
      lsu_we  <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (out_valid && need_lsu) begin
      lsu_addr_out <= lsu_addr;
      lsu_wdata    <= store_data << {lsu_addr[1:0], 3'b000};  // into byte lanes
      lsu_wmask    <= wmask << lsu_addr[1:0];
      ld_ctrl      <= load_ctrl;
    end
  end

  assign lsu_done = lsu_req && (lsu_wdone || lsu_rvalid);
  assign shifted  = rdata >> {lsu_addr_out[1:0], 3'b000};

  always_comb begin
    case (ld_ctrl)
      3'b000:  load_data = {{24{shifted[7]}}, shifted[7:0]};    // lb
      3'b001:  load_data = {{16{shifted[15]}}, shifted[15:0]};  // lh
      3'b100:  load_data = {24'b0, shifted[7:0]};               // lbu
      3'b101:  load_data = {16'b0, shifted[15:0]};              // lhu
      default: load_data = shifted;                             // lw
    endcase
  end

endmodule

// ==== logic/exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    in_valid,
  input  rv_pkg::opcode_t         op,
  input  logic [2:0]              func,
  input  logic [rv_pkg::xlen-1:0] src1,
  input  logic [rv_pkg::xlen-1:0] src2,
  input  logic [rv_pkg::xlen-1:0] imm,
  input  logic [rv_pkg::xlen-1:0] pc,
  output logic                    out_valid,
  output logic                    jump,
  output logic [rv_pkg::xlen-1:0] upc,
  output logic                    reg_wen,
  output logic [rv_pkg::xlen-1:0] wb_data,
  output logic                    need_lsu,
  output logic                    mem_wen,
  output logic [3:0]              wmask,
  output logic [2:0]              load_ctrl,
  output logic [rv_pkg::xlen-1:0] lsu_addr,
  output logic [rv_pkg::xlen-1:0] store_data
);
  import rv_pkg::*;

  opcode_t         op_q;
  logic [2:0]      func_q;
  logic [xlen-1:0] src1_q, src2_q, imm_q, pc_q;
  logic            is_imm, is_reg, is_load, is_store, is_branch;
  logic            is_jal, is_jalr, is_lui, is_auipc;
  logic [xlen-1:0] alu_a, alu_b, alu_result, base, sum;
  alu_op_t         alu_ctrl;
  logic            cond;

  always_ff @(posedge clock) begin
    if (reset) out_valid <= 1'b0;
    else out_valid <= in_valid;  // single cycle strobe
  end

  always_ff @(posedge clock) begin
    if (in_valid) begin
      op_q   <= op;
      func_q <= func;
      src1_q <= src1;
      src2_q <= src2;
      imm_q  <= imm;
      pc_q   <= pc;
    end
  end

  assign is_imm    = op_q == op_imm;
  assign is_reg    = op_q == op_reg;
  assign is_load   = op_q == op_load;
  assign is_store  = op_q == op_store;
  assign is_branch = op_q == op_branch;
  assign is_jal    = op_q == op_jal;
  assign is_jalr   = op_q == op_jalr;
  assign is_lui    = op_q == op_lui;
  assign is_auipc  = op_q == op_auipc;

  // links use pc + 4, lui uses 0 + imm
  assign alu_a = (is_jal || is_jalr || is_auipc) ? pc_q : is_lui ? '0 : src1_q;
  assign alu_b = (is_imm || is_lui || is_auipc) ? imm_q :
                 (is_jal || is_jalr) ? xlen'(4) : src2_q;

  always_comb begin
    if (is_branch) alu_ctrl = alu_op_t'({1'b1, func_q});  // compare only
    else if (is_reg && func_q == 3'b000 && imm_q[5]) alu_ctrl = alu_sub;
    else if (func_q == 3'b101 && ((is_reg && imm_q[5]) || (is_imm && imm_q[10])))
      alu_ctrl = alu_sra;  // funct7 bit 5 set
    else if (is_imm || is_reg) alu_ctrl = alu_op_t'({1'b0, func_q});
    else alu_ctrl = alu_add;
  end

  alu u_alu (
    .a      (alu_a),
    .b      (alu_b),
    .alu_op (alu_ctrl),
    .result (alu_result),
    .cond   (cond)
  );

  // one adder for jump targets and load/store addresses
  assign base = (is_jal || is_branch) ? pc_q : src1_q;
  assign sum  = base + imm_q;
  assign upc  = is_jalr ? {sum[xlen-1:1], 1'b0} : sum;  // jalr clears bit 0

  assign jump       = is_jal || is_jalr || (is_branch && cond);
  assign reg_wen    = !(is_store || is_branch);
  assign wb_data    = alu_result;
  assign need_lsu   = is_load || is_store;
  assign mem_wen    = is_store;
  assign wmask      = !is_store ? 4'b0000 : (func_q == 3'b000) ? 4'b0001 :
                      (func_q == 3'b001) ? 4'b0011 : 4'b1111;  // sb sh sw
  assign load_ctrl  = is_load ? func_q : 3'b000;
  assign lsu_addr   = sum;
  assign store_data = src2_q;

endmodule

// ==== logic/decode_unit.sv ====
`timescale 1ns/1ps

module decode_unit (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    inst_valid,
  input  logic [rv_pkg::xlen-1:0] inst,
  input  logic [rv_pkg::xlen-1:0] inst_pc,
  input  logic                    out_valid,
  input  logic                    need_lsu,
  input  logic                    reg_wen,
  input  logic [rv_pkg::xlen-1:0] wb_data,
  input  logic                    lsu_done,
  input  logic [rv_pkg::xlen-1:0] load_data,
  output logic                    in_valid,
  output rv_pkg::opcode_t         op,
  output logic [2:0]              func,
  output logic [rv_pkg::xlen-1:0] src1,
  output logic [rv_pkg::xlen-1:0] src2,
  output logic [rv_pkg::xlen-1:0] imm,
  output logic [rv_pkg::xlen-1:0] pc,
  output logic                    retire,
  output logic [rv_pkg::xlen-1:0] retire_pc,
  output logic                    retire_wen,
  output logic [4:0]              retire_rd,
  output logic [rv_pkg::xlen-1:0] retire_data
);
  import rv_pkg::*;

  logic [xlen-1:0] regs [32];  // x0 never read from here
  opcode_t         dec_op;
  logic [4:0]      rs1, rs2, rd, rd_q;
  logic [xlen-1:0] dec_imm, rdata1, rdata2;

  assign dec_op = opcode_t'(inst[6:0]);
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];
  assign rd     = inst[11:7];
  assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];  // x0 reads zero
  assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

  // immediate by format, R type carries funct7 for sub and sra
  always_comb begin
    case (dec_op)
      op_imm, op_load, op_jalr: dec_imm = {{20{inst[31]}}, inst[31:20]};
      op_store:  dec_imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      op_branch: dec_imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
      op_lui, op_auipc: dec_imm = {inst[31:12], 12'b0};
      op_jal: dec_imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      op_reg: dec_imm = {25'b0, inst[31:25]};
      default: dec_imm = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) in_valid <= 1'b0;
    else in_valid <= inst_valid;  // one cycle after the word arrives
  end

  always_ff @(posedge clock) begin
    if (inst_valid) begin
      op   <= dec_op;
      func <= inst[14:12];
      src1 <= rdata1;
      src2 <= rdata2;
      imm  <= dec_imm;
      pc   <= inst_pc;  // held until next instruction
      rd_q <= rd;
    end
  end

  assign retire      = (out_valid && !need_lsu) || lsu_done;
  assign retire_pc   = pc;
  assign retire_wen  = reg_wen;
  assign retire_rd   = rd_q;
  assign retire_data = lsu_done ? load_data : wb_data;  // load result or exec result

  always_ff @(posedge clock) begin
    if (retire && reg_wen && rd_q != 5'd0) regs[rd_q] <= retire_data;
  end

endmodule

// ==== logic/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    run,
  input  logic                    fetch_rvalid,
  input  logic [rv_pkg::xlen-1:0] rdata,
  input  logic                    retire,
  input  logic                    jump,
  input  logic [rv_pkg::xlen-1:0] upc,
  output logic                    fetch_req,
  output logic [rv_pkg::xlen-1:0] fetch_addr,
  output logic                    inst_valid,
  output logic [rv_pkg::xlen-1:0] inst,
  output logic [rv_pkg::xlen-1:0] inst_pc
);
  import rv_pkg::*;

  typedef enum logic [1:0] {
    s_idle,  // stopped, waits for run
    s_req,   // word at pc requested
    s_wait   // instruction in flight
  } state_t;

  state_t          state;
  logic [xlen-1:0] pc;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= s_idle;
      pc    <= '0;
    end else begin
      case (state)
        s_idle: if (run) state <= s_req;
        s_req: if (fetch_rvalid) state <= s_wait;
        s_wait: if (retire) begin
          pc    <= jump ? upc : pc + xlen'(4);  // taken target or next word
          state <= run ? s_req : s_idle;        // refetch one cycle after retire
        end
        default: state <= s_idle;
      endcase
    end
  end

  assign fetch_req  = state == s_req;
  assign fetch_addr = pc;
  assign inst_valid = state == s_req && fetch_rvalid;  // one pulse per word
  assign inst       = rdata;
  assign inst_pc    = pc;

endmodule

// ==== logic/alu.sv ====
`timescale 1ns/1ps

module alu (
  input  logic [rv_pkg::xlen-1:0] a,
  input  logic [rv_pkg::xlen-1:0] b,
  input  rv_pkg::alu_op_t         alu_op,
  output logic [rv_pkg::xlen-1:0] result,
  output logic                    cond
);
  import rv_pkg::*;

  logic [4:0] shamt;  // low five bits of b
  logic       lt_s, lt_u;

  assign shamt = b[4:0];
  assign lt_s  = $signed(a) < $signed(b);
  assign lt_u  = a < b;

  always_comb begin
    case (alu_op)
      alu_add:  result = a + b;
      alu_sub:  result = a - b;
      alu_sll:  result = a << shamt;
      alu_slt:  result = {{(xlen-1){1'b0}}, lt_s};
      alu_sltu: result = {{(xlen-1){1'b0}}, lt_u};
      alu_xor:  result = a ^ b;
      alu_sr:   result = a >> shamt;
      alu_sra:  result = $signed(a) >>> shamt;  // sign fill
      alu_or:   result = a | b;
      alu_and:  result = a & b;
      default:  result = '0;  // branch compares give no data
    endcase
  end

  always_comb begin
    case (alu_op)
      alu_beq:  cond = a == b;
      alu_bne:  cond = a != b;
      alu_blt:  cond = lt_s;
      alu_bge:  cond = !lt_s;
      alu_bltu: cond = lt_u;
      alu_bgeu: cond = !lt_u;
      default:  cond = 1'b0;
    endcase
  end

endmodule

// ==== logic/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter #(
  parameter int mem_words = 1024
) (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         load_we,
  input  logic [rv_pkg::xlen-1:0]      load_addr,
  input  logic [rv_pkg::xlen-1:0]      load_data,
  input  logic                         lsu_req,
  input  logic                         lsu_we,
  input  logic [rv_pkg::xlen-1:0]      lsu_addr,
  input  logic [rv_pkg::xlen-1:0]      lsu_wdata,
  input  logic [3:0]                   lsu_wmask,
  input  logic                         fetch_req,
  input  logic [rv_pkg::xlen-1:0]      fetch_addr,
  input  logic [rv_pkg::xlen-1:0]      mem_rdata,
  output logic                         lsu_rvalid,
  output logic                         lsu_wdone,
  output logic                         fetch_rvalid,
  output logic [rv_pkg::xlen-1:0]      rdata,
  output logic [$clog2(mem_words)-1:0] mem_addr,
  output logic [rv_pkg::xlen-1:0]      mem_wdata,
  output logic [3:0]                   mem_wmask,
  output logic                         mem_we
);
  import rv_pkg::*;

  localparam int aw = $clog2(mem_words);  // word index width

  requester_t grant;     // owner this cycle
  requester_t rd_grant;  // owner of the read returning now

  // fixed priority, a peer whose read is in flight is skipped
  always_comb begin
    if (load_we) grant = req_loader;
    else if (lsu_req && rd_grant != req_lsu) grant = req_lsu;
    else if (fetch_req && rd_grant != req_fetch) grant = req_fetch;
    else grant = req_none;
  end

  always_comb begin
    mem_addr  = fetch_addr[aw+1:2];  // byte to word index
    mem_wdata = lsu_wdata;
    mem_wmask = lsu_wmask;
    mem_we    = 1'b0;
    case (grant)
      req_loader: begin
        mem_addr  = load_addr[aw+1:2];
        mem_wdata = load_data;
        mem_wmask = 4'b1111;  // loader writes whole words
        mem_we    = 1'b1;
      end
      req_lsu: begin
        mem_addr = lsu_addr[aw+1:2];
        mem_we   = lsu_we;
      end
      default: mem_we = 1'b0;  // fetch reads, idle does nothing
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      rd_grant <= req_none;
    end else if (grant == req_fetch || (grant == req_lsu && !lsu_we)) begin
      rd_grant <= grant;  // data comes back next cycle
    end else begin
      rd_grant <= req_none;
    end
  end

  assign lsu_rvalid   = rd_grant == req_lsu;
  assign fetch_rvalid = rd_grant == req_fetch;
  assign lsu_wdone    = grant == req_lsu && lsu_we;  // write done in grant cycle
  assign rdata        = mem_rdata;  // shared return bus

endmodule

// ==== logic/unified_mem.sv ====
`timescale 1ns/1ps

module unified_mem #(
  parameter int mem_words = 1024
) (
  input  logic                         clock,
  input  logic [$clog2(mem_words)-1:0] addr,   // word index
  input  logic [rv_pkg::xlen-1:0]      wdata,
  input  logic [3:0]                   wmask,  // one bit per byte lane
  input  logic                         we,
  output logic [rv_pkg::xlen-1:0]      rdata
);
  import rv_pkg::*;

  logic [xlen-1:0] ram [mem_words];  // program and data share this array

  always_ff @(posedge clock) begin
    if (we) begin
      for (int i = 0; i < xlen / 8; i++) begin
        if (wmask[i]) begin
          ram[addr][8*i +: 8] <= wdata[8*i +: 8];  // only enabled lanes
        end
      end
    end
    rdata <= ram[addr];  // registered read, old data on a write
  end

endmodule

// ==== logic/rv_pkg.sv ====
package rv_pkg;

  localparam int xlen = 32;  // data path width

  // major opcodes kept in this core
  typedef enum logic [6:0] {
    op_load   = 7'b0000011,
    op_imm    = 7'b0010011,
    op_auipc  = 7'b0010111,
    op_store  = 7'b0100011,
    op_reg    = 7'b0110011,
    op_lui    = 7'b0110111,
    op_branch = 7'b1100011,
    op_jalr   = 7'b1100111,
    op_jal    = 7'b1101111
  } opcode_t;

  // low three bits follow funct3, top bit marks a branch compare
  typedef enum logic [3:0] {
    alu_add  = 4'b0000,
    alu_sll  = 4'b0001,
    alu_slt  = 4'b0010,
    alu_sltu = 4'b0011,
    alu_xor  = 4'b0100,
    alu_sr   = 4'b0101,  // logical right shift
    alu_or   = 4'b0110,
    alu_and  = 4'b0111,
    alu_beq  = 4'b1000,
    alu_bne  = 4'b1001,
    alu_sub  = 4'b1010,  // no branch uses funct3 010
    alu_sra  = 4'b1011,  // no branch uses funct3 011
    alu_blt  = 4'b1100,
    alu_bge  = 4'b1101,
    alu_bltu = 4'b1110,
    alu_bgeu = 4'b1111
  } alu_op_t;

  // memory grant owner
  typedef enum logic [1:0] {
    req_none,
    req_loader,
    req_lsu,
    req_fetch
  } requester_t;

endpackage
